// File: all.f
+incdir+.
mbDpPkg.sv
loadAlign.sv
gprFile.sv
storeAlign.sv
regfDatapath.sv
tb_regfDatapath.sv

// File: gprFile.sv
// ==========================================================
// General purpose register file, r0 to r31
// Two operand read ports, one store-data port with write
// forwarding, and one write port with a 4-way source mux
// ==========================================================
`timescale 1ns/1ps
`include "mbDp_consts.svh"

module gprFile (
   input  logic             gclk,
   input  logic             grst,
   input  logic             ena,
   input  mbDpPkg::regAddrT rdAddrA,
   input  mbDpPkg::regAddrT rdAddrB,
   output mbDpPkg::wordT    regA,
   output mbDpPkg::wordT    regB,
   input  mbDpPkg::wbReqT   wb,
   input  mbDpPkg::wordT    loadWord,
   input  mbDpPkg::byteSelT byteSel,
   input  mbDpPkg::regAddrT storeSrc,
   output mbDpPkg::wordT    storeWord
);

   import mbDpPkg::*;

   // One array with three read ports
   // The source core kept three LUT-RAM copies, one per read port
   wordT mem [0:`REG_N-1];

   // Current contents of the write target, used by keep
   wordT keepWord;
   // Selected write data
   wordT wrData;
   // Write requested by the pipeline, r0 excluded
   logic wrReq;
   // Write actually committed
   logic wrEn;
   // Store port takes the in-flight write value
   logic fwdStore;

   assign keepWord = mem[wb.wrAddr];

   // Write-source mux
   always_comb begin
      case (wb.sel)
         `WB_RESULT: wrData = wb.result;
         // Link address is word aligned, low bits zero
         `WB_LINK:   wrData = {wb.pcLink, 2'b00};
         `WB_LOAD:   wrData = loadWord;
         `WB_KEEP:   wrData = keepWord;
         default:    wrData = keepWord;
      endcase
   end

   assign wrReq = ena && (wb.wrAddr != '0);
   // Writes are held off during reset
   assign wrEn  = wrReq && !grst;

   // Contents have no reset, r0 is never written
   always_ff @(posedge gclk) begin
      if (wrEn) begin
         mem[wb.wrAddr] <= wrData;
      end
   end

   // Operand reads, r0 forced to zero
   assign regA = (rdAddrA == '0) ? '0 : mem[rdAddrA];
   assign regB = (rdAddrB == '0) ? '0 : mem[rdAddrB];

   // Forward when the store source is being written this cycle
   // Keep writes back the same value, so it needs no forward
   assign fwdStore = wrReq && (storeSrc == wb.wrAddr) && (wb.sel != `WB_KEEP);

   always_comb begin
      if (storeSrc == '0) begin
         storeWord = '0;
      end else if (fwdStore) begin
         storeWord = wrData;
      end else begin
         storeWord = mem[storeSrc];
      end
   end

   // Load data written back must come from a legal lane select
   assert property (@(posedge gclk) disable iff (grst)
      (ena && wb.sel == `WB_LOAD) |->
         (byteSel inside {4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'hF}))
      else $error("gprFile: illegal load byte select %h", byteSel);

   // Target register holds its value across a reset cycle
   assert property (@(posedge gclk)
      grst |=> (mem[$past(wb.wrAddr)] === $past(keepWord)))
      else $error("gprFile: register written during reset");

endmodule

// File: loadAlign.sv
// ==========================================================
// Load aligner
// Picks the addressed byte, halfword or word out of a bus
// read word and zero-extends it to a full data word
// ==========================================================
`timescale 1ns/1ps

module loadAlign (
   input  mbDpPkg::byteSelT byteSel,
   input  mbDpPkg::wordT    busWord,
   output mbDpPkg::wordT    loadWord
);

   // Purely combinational, no pipeline state here
   always_comb begin
      // Zero fill covers the extension and illegal selects
      loadWord = '0;
      case (byteSel)
         // Single byte lanes, lane 8 is the MSB lane
         4'h8: begin
            loadWord[7:0] = busWord[31:24];
         end
         4'h4: begin
            loadWord[7:0] = busWord[23:16];
         end
         4'h2: begin
            loadWord[7:0] = busWord[15:8];
         end
         4'h1: begin
            loadWord[7:0] = busWord[7:0];
         end
         // Upper halfword
         4'hC: begin
            loadWord[15:0] = busWord[31:16];
         end
         // Lower halfword
         4'h3: begin
            loadWord[15:0] = busWord[15:0];
         end
         // Full word passes untouched
         4'hF: begin
            loadWord = busWord;
         end
         // Anything else leaves the word at zero
         // Legality is checked where the load is consumed
         default: begin
            loadWord = '0;
         end
      endcase
   end

endmodule

// File: mbDpPkg.sv
// ==========================================================
// Datapath types package
// Vector typedefs and the write-back and store request
// structs driven by the instruction decoder
// ==========================================================
`include "mbDp_consts.svh"

package mbDpPkg;

   // Plain data word as seen on the data bus
   typedef logic [`DATA_W-1:0]   wordT;

   // Register number, r0 is hard zero
   typedef logic [`REG_AW-1:0]   regAddrT;

   // Upper PC bits, word aligned
   typedef logic [`LINK_W-1:0]   linkT;

   // Byte-lane select for loads
   // One lane 1/2/4/8, halfword 3/C, full word F
   typedef logic [`BSEL_W-1:0]   byteSelT;

   // Write-source select and store size
   typedef logic [`WB_SEL_W-1:0] wbSelT;
   typedef logic [`SIZE_W-1:0]   sizeT;

   // Write-back request, one per pipeline step
   typedef struct packed {
      regAddrT wrAddr;
      wbSelT   sel;
      wordT    result;
      linkT    pcLink;
   } wbReqT;

   // Store request
   // srcAddr names the register that holds the store data
   typedef struct packed {
      regAddrT srcAddr;
      sizeT    size;
   } storeReqT;

endpackage

// File: mbDp_consts.svh
// ==========================================================
// Register and memory-data datapath constants
// Widths, write-source codes and store size codes
// ==========================================================
`ifndef MBDP_CONSTS_SVH
`define MBDP_CONSTS_SVH

// Data word and register file geometry
`define DATA_W    32
`define REG_AW    5
`define REG_N     32
// Link address drops the two byte-offset bits of the PC
`define LINK_W    (`DATA_W - 2)
`define BSEL_W    4
`define WB_SEL_W  2
`define SIZE_W    2

// Write-source select codes
`define WB_RESULT 2'd0
`define WB_LINK   2'd1
`define WB_LOAD   2'd2
`define WB_KEEP   2'd3

// Store size codes, code 3 is unused
`define SZ_BYTE   2'd0
`define SZ_HALF   2'd1
`define SZ_WORD   2'd2

`endif

// File: regfDatapath.sv
// ==========================================================
// Register and memory-data datapath, top level
// Load aligner feeding the register file, whose store port
// drives the store aligner toward the data bus
// ==========================================================
`timescale 1ns/1ps

module regfDatapath (
   input  logic              gclk,
   input  logic              grst,
   input  logic              ena,
   input  mbDpPkg::regAddrT  rdAddrA,
   input  mbDpPkg::regAddrT  rdAddrB,
   output mbDpPkg::wordT     regA,
   output mbDpPkg::wordT     regB,
   input  mbDpPkg::wbReqT    wb,
   input  mbDpPkg::byteSelT  loadByteSel,
   input  mbDpPkg::wordT     busDataIn,
   output mbDpPkg::wordT     loadAligned,
   input  mbDpPkg::storeReqT store,
   output mbDpPkg::wordT     busDataOut
);

   import mbDpPkg::*;

   // Store data after forwarding, into the store aligner
   wordT storeWord;

   // Bus read word to zero-extended load data
   loadAlign loadAlign_i (
      .byteSel  (loadByteSel),
      .busWord  (busDataIn),
      .loadWord (loadAligned)
   );

   // Register file, load data is one write source
   gprFile gprFile_i (
      .gclk      (gclk),
      .grst      (grst),
      .ena       (ena),
      .rdAddrA   (rdAddrA),
      .rdAddrB   (rdAddrB),
      .regA      (regA),
      .regB      (regB),
      .wb        (wb),
      .loadWord  (loadAligned),
      .byteSel   (loadByteSel),
      .storeSrc  (store.srcAddr),
      .storeWord (storeWord)
   );

   // Lane replication and bus output register
   storeAlign storeAlign_i (
      .gclk       (gclk),
      .grst       (grst),
      .ena        (ena),
      .size       (store.size),
      .storeWord  (storeWord),
      .busDataOut (busDataOut)
   );

endmodule

// File: run.sh
#!/bin/sh
# Build the datapath testbench with Verilator and run it
# Exit status is nonzero when the build, the run or a check fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_regfDatapath

rm -rf obj_dir "$LOG"

verilator --binary --assert --timescale 1ns/1ps -f all.f --top-module "$TOP" -o simv
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The testbench prints the fail message on any failed check or timeout
if grep -q "ERRORS FOUND" "$LOG"; then
   echo "Simulation reported failures"
   exit 1
fi
if ! grep -q "NO ERRORS" "$LOG"; then
   echo "Simulation ended without a result line"
   exit 1
fi
echo "Simulation passed"
exit 0

// File: storeAlign.sv
// ==========================================================
// Store aligner
// Copies store data across all byte lanes by access size
// and registers the result toward the data bus
// ==========================================================
`timescale 1ns/1ps
`include "mbDp_consts.svh"

module storeAlign (
   input  logic          gclk,
   input  logic          grst,
   input  logic          ena,
   input  mbDpPkg::sizeT size,
   input  mbDpPkg::wordT storeWord,
   output mbDpPkg::wordT busDataOut
);

   import mbDpPkg::*;

   // Number of byte lanes on the bus
   localparam int LANES = `DATA_W / 8;

   // Lane-replicated word before the output register
   wordT laneWord;

   always_comb begin
      case (size)
         // Low byte into every lane
         `SZ_BYTE: begin
            laneWord = {LANES{storeWord[7:0]}};
         end
         // Low halfword into both halves
         `SZ_HALF: begin
            laneWord = {(LANES / 2){storeWord[15:0]}};
         end
         `SZ_WORD: begin
            laneWord = storeWord;
         end
         // Unused size code drives zero
         default: begin
            laneWord = '0;
         end
      endcase
   end

   // One cycle to the bus, advancing with the pipeline
   always_ff @(posedge gclk) begin
      if (grst) begin
         busDataOut <= '0;
      end else if (ena) begin
         busDataOut <= laneWord;
      end
   end

   // Decoder never issues size code 3 on a live step
   assert property (@(posedge gclk) disable iff (grst)
      ena |-> (size != 2'd3))
      else $error("storeAlign: reserved store size on enabled edge");

endmodule

// File: tb_regfDatapath.sv
// ==========================================================
// Testbench for the register and memory-data datapath
// Table-driven stimulus, one request per cycle, checked
// against a reference model of the register contents
// ==========================================================
`timescale 1ns/1ps
`include "mbDp_consts.svh"

module tb_regfDatapath;

   import mbDpPkg::*;

   // One table row per pipeline step
   typedef struct packed {
      logic    ena;
      regAddrT wrAddr;
      wbSelT   sel;
      wordT    result;
      linkT    pcLink;
      byteSelT byteSel;
      wordT    busIn;
      regAddrT srcAddr;
      sizeT    size;
      regAddrT rdA;
      regAddrT rdB;
      logic [3:0] chk;
   } rowT;

   // Check flags per row
   localparam logic [3:0] CHK_A   = 4'b0001;
   localparam logic [3:0] CHK_B   = 4'b0010;
   localparam logic [3:0] CHK_LD  = 4'b0100;
   // Bus check applies after the edge that ends the row
   localparam logic [3:0] CHK_BUS = 4'b1000;

   logic     gclk;
   logic     grst;
   logic     ena;
   regAddrT  rdAddrA;
   regAddrT  rdAddrB;
   wordT     regA;
   wordT     regB;
   wbReqT    wb;
   byteSelT  loadByteSel;
   wordT     busDataIn;
   wordT     loadAligned;
   storeReqT store;
   wordT     busDataOut;

   rowT stim [$];

   // Reference register file that stays invalid until first write
   wordT refRegs [0:31];
   logic refValid [0:31];
   // Expected bus word of the last enabled cycle
   wordT expBus;
   logic busKnown;

   int wordErrs;
   int busErrs;
   int checkCount;
   int cycleCnt;
   int maxCycles;

   regfDatapath dut_i (
      .gclk        (gclk),
      .grst        (grst),
      .ena         (ena),
      .rdAddrA     (rdAddrA),
      .rdAddrB     (rdAddrB),
      .regA        (regA),
      .regB        (regB),
      .wb          (wb),
      .loadByteSel (loadByteSel),
      .busDataIn   (busDataIn),
      .loadAligned (loadAligned),
      .store       (store),
      .busDataOut  (busDataOut)
   );

   // 8 ns clock
   always #4 gclk = ~gclk;

   // Cycle limit guard
   always @(posedge gclk) begin
      cycleCnt = cycleCnt + 1;
      if (cycleCnt > maxCycles) begin
         $display("Timeout: run went past the limit of %0d cycles", maxCycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // Append a row with data fields from the generator
   task automatic addRow(input logic en, input regAddrT wr, input wbSelT sel,
                         input byteSelT bsel, input regAddrT src, input sizeT sz,
                         input regAddrT ra, input regAddrT rb, input logic [3:0] chk);
      rowT r;
      r.ena     = en;
      r.wrAddr  = wr;
      r.sel     = sel;
      r.result  = $urandom();
      r.pcLink  = linkT'($urandom());
      r.byteSel = bsel;
      r.busIn   = $urandom();
      r.srcAddr = src;
      r.size    = sz;
      r.rdA     = ra;
      r.rdB     = rb;
      r.chk     = chk;
      stim.push_back(r);
   endtask

   // Lane rule keeps the selected lanes and shifts the lowest one down to bit 0
   function automatic wordT alignLoad(byteSelT sel, wordT w);
      wordT mask;
      int   shift;
      mask  = '0;
      shift = -1;
      for (int l = 0; l < 4; l++) begin
         if (sel[l]) begin
            mask[l*8 +: 8] = 8'hFF;
            if (shift < 0) begin
               shift = l * 8;
            end
         end
      end
      if (shift < 0) begin
         return '0;
      end
      return (w & mask) >> shift;
   endfunction

   // Copy rule by multiplication with a lane pattern
   function automatic wordT laneCopy(sizeT sz, wordT w);
      case (sz)
         `SZ_BYTE: return {24'h0, w[7:0]} * 32'h0101_0101;
         `SZ_HALF: return {16'h0, w[15:0]} * 32'h0001_0001;
         `SZ_WORD: return w;
         default:  return '0;
      endcase
   endfunction

   // Value the write port would commit for this row
   function automatic wordT writeValue(rowT r);
      case (r.sel)
         `WB_RESULT: return r.result;
         `WB_LINK:   return {r.pcLink, 2'b00};
         `WB_LOAD:   return alignLoad(r.byteSel, r.busIn);
         default:    return refRegs[r.wrAddr];
      endcase
   endfunction

   task automatic checkWord(input string port, input wordT exp, input wordT act);
      checkCount++;
      if (act !== exp) begin
         $display("FAIL %0t %s expected %h got %h", $time, port, exp, act);
         wordErrs++;
      end
   endtask

   task automatic checkBus(input wordT exp, input wordT act);
      checkCount++;
      if (act !== exp) begin
         $display("FAIL %0t busDataOut expected %h got %h", $time, exp, act);
         busErrs++;
      end
   endtask

   task automatic driveRow(input rowT r);
      ena           = r.ena;
      wb.wrAddr     = r.wrAddr;
      wb.sel        = r.sel;
      wb.result     = r.result;
      wb.pcLink     = r.pcLink;
      loadByteSel   = r.byteSel;
      busDataIn     = r.busIn;
      store.srcAddr = r.srcAddr;
      store.size    = r.size;
      rdAddrA       = r.rdA;
      rdAddrB       = r.rdB;
   endtask

   initial begin
      rowT  r;
      wordT wData;
      wordT srcVal;
      logic srcKnown;

      void'($urandom(4));
      gclk        = 1'b0;
      grst        = 1'b1;
      ena         = 1'b0;
      rdAddrA     = '0;
      rdAddrB     = '0;
      wb          = '0;
      loadByteSel = 4'hF;
      busDataIn   = '0;
      store       = '0;
      wordErrs    = 0;
      busErrs     = 0;
      checkCount  = 0;
      cycleCnt    = 0;
      for (int k = 0; k < 32; k++) begin
         refRegs[k]  = 'x;
         refValid[k] = 1'b0;
      end
      refRegs[0]  = '0;
      refValid[0] = 1'b1;

      // Result, link and load writes read back next cycle
      addRow(1'b1, 5'd1, `WB_RESULT, 4'hF, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_A | CHK_B);
      addRow(1'b1, 5'd2, `WB_LINK,   4'hF, 5'd0, `SZ_WORD, 5'd1, 5'd0, CHK_A | CHK_B);
      addRow(1'b1, 5'd3, `WB_LOAD,   4'hF, 5'd0, `SZ_WORD, 5'd1, 5'd2, CHK_A | CHK_B | CHK_LD);
      addRow(1'b1, 5'd4, `WB_LOAD,   4'h8, 5'd0, `SZ_WORD, 5'd2, 5'd3, CHK_A | CHK_B | CHK_LD);
      addRow(1'b1, 5'd5, `WB_LOAD,   4'hC, 5'd0, `SZ_WORD, 5'd3, 5'd4, CHK_A | CHK_B | CHK_LD);
      addRow(1'b1, 5'd6, `WB_LINK,   4'hF, 5'd0, `SZ_WORD, 5'd4, 5'd5, CHK_A | CHK_B);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd0, `SZ_WORD, 5'd5, 5'd6, CHK_A | CHK_B);
      // r0 with every source, then keep on live registers
      addRow(1'b1, 5'd0, `WB_LINK,   4'hF, 5'd0, `SZ_WORD, 5'd0, 5'd1, CHK_A | CHK_B);
      addRow(1'b1, 5'd0, `WB_LOAD,   4'hF, 5'd0, `SZ_WORD, 5'd0, 5'd2, CHK_A | CHK_B);
      addRow(1'b1, 5'd0, `WB_KEEP,   4'hF, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_A | CHK_B);
      addRow(1'b1, 5'd1, `WB_KEEP,   4'hF, 5'd0, `SZ_WORD, 5'd1, 5'd0, CHK_A);
      addRow(1'b1, 5'd2, `WB_KEEP,   4'hF, 5'd0, `SZ_WORD, 5'd1, 5'd2, CHK_A | CHK_B);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd0, `SZ_WORD, 5'd2, 5'd0, CHK_A | CHK_B);
      // Every legal lane select on random bus words
      addRow(1'b1, 5'd0, `WB_RESULT, 4'h1, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_LD);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'h2, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_LD);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'h4, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_LD);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'h8, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_LD);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'h3, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_LD);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hC, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_LD);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_LD);
      addRow(1'b1, 5'd7, `WB_LOAD,   4'h2, 5'd0, `SZ_WORD, 5'd0, 5'd0, CHK_LD);
      addRow(1'b1, 5'd8, `WB_LOAD,   4'h3, 5'd0, `SZ_WORD, 5'd7, 5'd0, CHK_A | CHK_LD);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd0, `SZ_WORD, 5'd8, 5'd7, CHK_A | CHK_B);
      // Stores of each size, then stores from a register being written
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd1, `SZ_BYTE, 5'd0, 5'd0, CHK_BUS);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd2, `SZ_HALF, 5'd0, 5'd0, CHK_BUS);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd3, `SZ_WORD, 5'd0, 5'd0, CHK_BUS);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd4, `SZ_BYTE, 5'd0, 5'd0, CHK_BUS);
      addRow(1'b1, 5'd9,  `WB_RESULT, 4'hF, 5'd9,  `SZ_WORD, 5'd0,  5'd0, CHK_BUS);
      addRow(1'b1, 5'd10, `WB_LOAD,   4'h4, 5'd10, `SZ_BYTE, 5'd9,  5'd0, CHK_A | CHK_BUS);
      addRow(1'b1, 5'd11, `WB_LINK,   4'hF, 5'd11, `SZ_HALF, 5'd10, 5'd0, CHK_A | CHK_BUS);
      addRow(1'b1, 5'd5,  `WB_KEEP,   4'hF, 5'd5,  `SZ_HALF, 5'd11, 5'd0, CHK_A | CHK_BUS);
      addRow(1'b1, 5'd0,  `WB_RESULT, 4'hF, 5'd0,  `SZ_WORD, 5'd5,  5'd0, CHK_A | CHK_BUS);
      // Stall with no write while the bus output holds
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd3, `SZ_WORD, 5'd0, 5'd0, CHK_BUS);
      addRow(1'b0, 5'd1, `WB_RESULT, 4'hF, 5'd6, `SZ_BYTE, 5'd1, 5'd3, CHK_A | CHK_B | CHK_BUS);
      addRow(1'b0, 5'd3, `WB_LINK,   4'hF, 5'd4, `SZ_HALF, 5'd3, 5'd1, CHK_A | CHK_B | CHK_BUS);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd2, `SZ_WORD, 5'd1, 5'd3, CHK_A | CHK_B | CHK_BUS);
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd0, `SZ_BYTE, 5'd0, 5'd0, CHK_BUS);
      // Leave a nonzero word on the bus ahead of the second reset
      addRow(1'b1, 5'd0, `WB_RESULT, 4'hF, 5'd1, `SZ_WORD, 5'd0, 5'd0, CHK_BUS);

      maxCycles = 2 * stim.size() + 20;

      // Reset for two edges clears the bus output
      repeat (2) @(posedge gclk);
      #1;
      grst     = 1'b0;
      expBus   = '0;
      busKnown = 1'b1;
      checkBus(expBus, busDataOut);

      for (int i = 0; i < stim.size(); i++) begin
         r = stim[i];
         driveRow(r);
         // Combinational outputs settle well before the next edge
         #3;
         if (((r.chk & CHK_A) != 0) && refValid[r.rdA]) begin
            checkWord("regA", refRegs[r.rdA], regA);
         end
         if (((r.chk & CHK_B) != 0) && refValid[r.rdB]) begin
            checkWord("regB", refRegs[r.rdB], regB);
         end
         if ((r.chk & CHK_LD) != 0) begin
            checkWord("loadAligned", alignLoad(r.byteSel, r.busIn), loadAligned);
         end

         wData = writeValue(r);
         // Store source value with forwarding from a write in this step
         if (r.srcAddr == '0) begin
            srcVal   = '0;
            srcKnown = 1'b1;
         end else if (r.ena && r.wrAddr != '0 && r.wrAddr == r.srcAddr &&
                      r.sel != `WB_KEEP) begin
            srcVal   = wData;
            srcKnown = 1'b1;
         end else begin
            srcVal   = refRegs[r.srcAddr];
            srcKnown = refValid[r.srcAddr];
         end
         if (r.ena) begin
            expBus   = laneCopy(r.size, srcVal);
            busKnown = srcKnown;
         end
         if (r.ena && r.wrAddr != '0) begin
            refRegs[r.wrAddr] = wData;
            if (r.sel != `WB_KEEP) begin
               refValid[r.wrAddr] = 1'b1;
            end
         end

         @(posedge gclk);
         #1;
         if (((r.chk & CHK_BUS) != 0) && busKnown) begin
            checkBus(expBus, busDataOut);
         end
      end

      // Reset in the middle of the run clears the bus word of the last store
      grst = 1'b1;
      repeat (2) @(posedge gclk);
      #1;
      checkBus('0, busDataOut);
      grst = 1'b0;

      $display("Checks run: %0d, word errors: %0d, bus errors: %0d",
               checkCount, wordErrs, busErrs);
      if (wordErrs == 0 && busErrs == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
